//--- filelist.f
rtl/ild_pkg.sv
rtl/ild_fetch_latch.sv
rtl/ild_byte_decoder.sv
rtl/ild_length_chain.sv
rtl/ild_top.sv
verification/ild_checker.sv
verification/ild_tb.sv

//--- rtl/ild_byte_decoder.sv
`timescale 1ns/10ps

module ild_byte_decoder (
	input  logic                      clk,
	input  logic                      rst_i,
	// Pipeline advance level
	input  logic                      en_i,
	// One byte of the latched line, decoded as if an instruction began here
	input  logic [7:0]                byte_i,
	// Registered instruction length for this byte position
	output logic [ild_pkg::LEN_W-1:0] len_o
);

	import ild_pkg::*;

	// Opcode class of this byte position
	opclass_e               cls;

	// Length before the pipeline register
	logic [LEN_W-1:0]       len_d;

	// ==============================
	// Class decode
	// ==============================

	// Only the top three bits matter for the length
	// The low five bits are operand or register fields
	assign cls = opclass_e'(byte_i[7:5]);

	// Table lookup from the shared class rule
	assign len_d = class_length(cls);

	// ==============================
	// Length register
	// ==============================

	// Holds the length while the chain selects from it
	// Reset value matches a NOP so the chain walks one byte at a time
	always_ff @(posedge clk) begin
		if (rst_i) begin
			len_o <= LEN_W'(1);
		end else if (en_i) begin
			len_o <= len_d;
		end
	end

endmodule

//--- rtl/ild_fetch_latch.sv
`timescale 1ns/10ps

module ild_fetch_latch (
	input  logic                       clk,
	input  logic                       rst_i,
	// Pipeline advance level, shared by every stage
	input  logic                       en_i,
	// Incoming cache line and its sideband
	input  logic [ild_pkg::LINE_W-1:0] line_i,
	input  logic [ild_pkg::PC_W-1:0]   pc_i,
	input  logic                       hit_i,
	input  logic [2:0]                 grp_i,
	// Registered copies for the decoder array and the chain
	output logic [ild_pkg::LINE_W-1:0] line_o,
	output logic [ild_pkg::PC_W-1:0]   pc_o,
	output logic                       hit_o,
	output logic [2:0]                 grp_o
);

	import ild_pkg::*;

	// ==============================
	// Line register
	// ==============================

	// The line is the bulk of the stage
	// Every byte of it is sliced off by the decoder array in the top level
	// After reset it holds NOP bytes, so the decoders start at length 1
	always_ff @(posedge clk) begin
		if (rst_i) begin
			line_o <= RST_LINE;
		end else if (en_i) begin
			line_o <= line_i;
		end
	end

	// ==============================
	// Sideband registers
	// ==============================

	// The pc picks the start offset further down the pipe
	// It travels with the line so that both leave on the same edge
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_o <= RST_PC;
		end else if (en_i) begin
			pc_o <= pc_i;
		end
	end

	// Hit and group are only carried along
	// They obey the same enable as the line so nothing slips out of step
	always_ff @(posedge clk) begin
		if (rst_i) begin
			hit_o <= 1'b0;
			grp_o <= 3'd0;
		end else if (en_i) begin
			hit_o <= hit_i;
			grp_o <= grp_i;
		end
	end

endmodule

//--- rtl/ild_length_chain.sv
`timescale 1ns/10ps

module ild_length_chain (
	input  logic                                             clk,
	input  logic                                             rst_i,
	// Pipeline advance level
	input  logic                                             en_i,
	// Registered length of every byte position in the line
	input  logic [ild_pkg::LINE_BYTES-1:0][ild_pkg::LEN_W-1:0] len_i,
	// Sideband straight from the fetch latch, one stage early
	input  logic [ild_pkg::LINE_W-1:0]                      line_i,
	input  logic [ild_pkg::PC_W-1:0]                        pc_i,
	input  logic                                             hit_i,
	input  logic [2:0]                                       grp_i,
	// Results, aligned with the line they belong to
	output logic [ild_pkg::LINE_W-1:0]                      line_o,
	output logic [ild_pkg::PC_W-1:0]                        pc_o,
	output logic                                             hit_o,
	output logic [2:0]                                       grp_o,
	output logic [ild_pkg::LEN_W-1:0]                       len0_o,
	output logic [ild_pkg::LEN_W-1:0]                       len1_o,
	output logic [ild_pkg::LEN_W-1:0]                       len2_o,
	output logic [ild_pkg::LEN_W-1:0]                       len3_o
);

	import ild_pkg::*;

	// Sideband delayed to line up with the decoder registers
	logic [LINE_W-1:0]                   d_line;
	logic [PC_W-1:0]                     d_pc;
	logic                                d_hit;
	logic [2:0]                          d_grp;

	// Stage A selection, combinational
	logic [OFS_W-1:0]                    a_start;
	logic [OFS_W-1:0]                    a_pos1;
	logic [LEN_W-1:0]                    a_sel0;
	logic [LEN_W-1:0]                    a_sel1;

	// Stage A registers
	logic [LEN_W-1:0]                    a_len0_q;
	logic [LEN_W-1:0]                    a_len1_q;
	logic [OFS_W-1:0]                    a_sum_q;
	logic [OFS_W-1:0]                    a_ofs_q;
	logic [LINE_BYTES-1:0][LEN_W-1:0]    a_lens_q;
	logic [LINE_W-1:0]                   a_line_q;
	logic [PC_W-1:0]                     a_pc_q;
	logic                                a_hit_q;
	logic [2:0]                          a_grp_q;

	// Stage B selection, combinational
	logic [OFS_W-1:0]                    b_pos2;
	logic [OFS_W-1:0]                    b_pos3;
	logic [LEN_W-1:0]                    b_sel2;
	logic [LEN_W-1:0]                    b_sel3;

	// Stage B output lengths, slot 0 first
	logic [NUM_SLOTS-1:0][LEN_W-1:0]     slot_q;

	// ==============================
	// Sideband delay
	// ==============================

	// The decoders add a register after the fetch latch
	// Same delay here keeps pc and line beside their lengths
	always_ff @(posedge clk) begin
		if (rst_i) begin
			d_line <= RST_LINE;
			d_pc   <= RST_PC;
			d_hit  <= 1'b0;
			d_grp  <= 3'd0;
		end else if (en_i) begin
			d_line <= line_i;
			d_pc   <= pc_i;
			d_hit  <= hit_i;
			d_grp  <= grp_i;
		end
	end

	// ==============================
	// Stage A
	// ==============================

	// First instruction starts where the pc points inside the line
	assign a_start = d_pc[OFS_W-1:0];
	assign a_sel0  = len_i[a_start];

	// Offsets are OFS_W wide so the add wraps around the line
	assign a_pos1  = a_start + OFS_W'(a_sel0);
	assign a_sel1  = len_i[a_pos1];

	// The whole length array moves along too, stage B picks from it
	always_ff @(posedge clk) begin
		if (rst_i) begin
			a_len0_q <= LEN_W'(1);
			a_len1_q <= LEN_W'(1);
			a_sum_q  <= OFS_W'(2);
			a_ofs_q  <= RST_PC[OFS_W-1:0];
			a_lens_q <= {LINE_BYTES{LEN_W'(1)}};
			a_line_q <= RST_LINE;
			a_pc_q   <= RST_PC;
			a_hit_q  <= 1'b0;
			a_grp_q  <= 3'd0;
		end else if (en_i) begin
			a_len0_q <= a_sel0;
			a_len1_q <= a_sel1;
			a_sum_q  <= OFS_W'(a_sel0) + OFS_W'(a_sel1);
			a_ofs_q  <= a_start;
			a_lens_q <= len_i;
			a_line_q <= d_line;
			a_pc_q   <= d_pc;
			a_hit_q  <= d_hit;
			a_grp_q  <= d_grp;
		end
	end

	// ==============================
	// Stage B
	// ==============================

	// Third instruction begins past the first two
	assign b_pos2 = a_ofs_q + a_sum_q;
	assign b_sel2 = a_lens_q[b_pos2];

	// Fourth one follows the third, again modulo the line size
	assign b_pos3 = b_pos2 + OFS_W'(b_sel2);
	assign b_sel3 = a_lens_q[b_pos3];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			slot_q <= {NUM_SLOTS{LEN_W'(1)}};
			line_o <= RST_LINE;
			pc_o   <= RST_PC;
			hit_o  <= 1'b0;
			grp_o  <= 3'd0;
		end else if (en_i) begin
			slot_q <= {b_sel3, b_sel2, a_len1_q, a_len0_q};
			line_o <= a_line_q;
			pc_o   <= a_pc_q;
			hit_o  <= a_hit_q;
			grp_o  <= a_grp_q;
		end
	end

	// Slots fan out to the individual length ports
	assign len0_o = slot_q[0];
	assign len1_o = slot_q[1];
	assign len2_o = slot_q[2];
	assign len3_o = slot_q[3];

endmodule

//--- rtl/ild_pkg.sv
package ild_pkg;

	// ==============================
	// Line geometry
	// ==============================

	// Bytes in one fetched cache line
	localparam int LINE_BYTES = 32;

	// Full line width in bits
	localparam int LINE_W = LINE_BYTES * 8;

	// Byte offset inside a line, taken from the low pc bits
	localparam int OFS_W = $clog2(LINE_BYTES);

	// One instruction length holds 1 to 8
	localparam int LEN_W = 4;

	// Number of instruction lengths reported for each line
	localparam int NUM_SLOTS = 4;

	// Program counter width
	localparam int PC_W = 32;

	// ==============================
	// Reset values
	// ==============================

	// Fetch address after reset
	localparam logic [PC_W-1:0] RST_PC = 32'hFFFC0000;

	// An all ones line decodes as a run of NOP bytes
	localparam logic [LINE_W-1:0] RST_LINE = '1;

	// ==============================
	// Opcode classes
	// ==============================

	// Class field sits in bits 7 to 5 of the first instruction byte
	// NOP is encoded as all ones so that an erased line is harmless
	typedef enum logic [2:0] {
		OPC_ALU    = 3'd0,
		OPC_IMM8   = 3'd1,
		OPC_MEM    = 3'd2,
		OPC_IMM16  = 3'd3,
		OPC_BRANCH = 3'd4,
		OPC_IMM32  = 3'd5,
		OPC_LONG   = 3'd6,
		OPC_NOP    = 3'd7
	} opclass_e;

	// Instruction length in bytes for each opcode class
	function automatic logic [LEN_W-1:0] class_length(input opclass_e cls);
		case (cls)
			OPC_ALU:    class_length = LEN_W'(1);
			OPC_IMM8:   class_length = LEN_W'(2);
			OPC_MEM:    class_length = LEN_W'(3);
			OPC_IMM16:  class_length = LEN_W'(4);
			OPC_BRANCH: class_length = LEN_W'(5);
			OPC_IMM32:  class_length = LEN_W'(6);
			OPC_LONG:   class_length = LEN_W'(8);
			OPC_NOP:    class_length = LEN_W'(1);
			default:    class_length = LEN_W'(1);
		endcase
	endfunction

endpackage

//--- rtl/ild_top.sv
`timescale 1ns/10ps

module ild_top (
	input  logic                       clk,
	input  logic                       rst_i,
	// Advances every stage at once, low means hold
	input  logic                       en_i,
	// Fetched line with its sideband
	input  logic [ild_pkg::LINE_W-1:0] line_i,
	input  logic [ild_pkg::PC_W-1:0]   pc_i,
	input  logic                       hit_i,
	input  logic [2:0]                 grp_i,
	// Line and sideband, four enabled cycles later
	output logic [ild_pkg::LINE_W-1:0] line_o,
	output logic [ild_pkg::PC_W-1:0]   pc_o,
	output logic                       hit_o,
	output logic [2:0]                 grp_o,
	// Lengths of the first four instructions from the pc offset
	output logic [ild_pkg::LEN_W-1:0]  len0_o,
	output logic [ild_pkg::LEN_W-1:0]  len1_o,
	output logic [ild_pkg::LEN_W-1:0]  len2_o,
	output logic [ild_pkg::LEN_W-1:0]  len3_o
);

	import ild_pkg::*;

	// Fetch latch outputs
	logic [LINE_W-1:0]                lat_line;
	logic [PC_W-1:0]                  lat_pc;
	logic                             lat_hit;
	logic [2:0]                       lat_grp;

	// One registered length per byte position
	logic [LINE_BYTES-1:0][LEN_W-1:0] dec_len;

	// ==============================
	// Entry register
	// ==============================

	ild_fetch_latch u_latch (
		.clk    (clk),
		.rst_i  (rst_i),
		.en_i   (en_i),
		.line_i (line_i),
		.pc_i   (pc_i),
		.hit_i  (hit_i),
		.grp_i  (grp_i),
		.line_o (lat_line),
		.pc_o   (lat_pc),
		.hit_o  (lat_hit),
		.grp_o  (lat_grp)
	);

	// ==============================
	// Byte decoder array
	// ==============================

	// Every byte is decoded in parallel since any of them may start an instruction
	// The chain later picks the few that really do
	genvar g;
	generate
		for (g = 0; g < LINE_BYTES; g++) begin : g_dec
			ild_byte_decoder u_dec (
				.clk    (clk),
				.rst_i  (rst_i),
				.en_i   (en_i),
				.byte_i (lat_line[g*8 +: 8]),
				.len_o  (dec_len[g])
			);
		end
	endgenerate

	// ==============================
	// Length walk
	// ==============================

	// Gets the sideband one stage early and delays it itself
	ild_length_chain u_chain (
		.clk    (clk),
		.rst_i  (rst_i),
		.en_i   (en_i),
		.len_i  (dec_len),
		.line_i (lat_line),
		.pc_i   (lat_pc),
		.hit_i  (lat_hit),
		.grp_i  (lat_grp),
		.line_o (line_o),
		.pc_o   (pc_o),
		.hit_o  (hit_o),
		.grp_o  (grp_o),
		.len0_o (len0_o),
		.len1_o (len1_o),
		.len2_o (len2_o),
		.len3_o (len3_o)
	);

endmodule

//--- verification/ild_checker.sv
`timescale 1ns/10ps

module ild_checker (
	input logic                       clk,
	input logic                       rst_i,
	input logic                       en_i,
	input logic [ild_pkg::LINE_W-1:0] line_o,
	input logic [ild_pkg::PC_W-1:0]   pc_o,
	input logic                       hit_o,
	input logic [2:0]                 grp_o,
	input logic [ild_pkg::LEN_W-1:0]  len0_o,
	input logic [ild_pkg::LEN_W-1:0]  len1_o,
	input logic [ild_pkg::LEN_W-1:0]  len2_o,
	input logic [ild_pkg::LEN_W-1:0]  len3_o
);

	import ild_pkg::*;

	// Legal instruction lengths run from 1 to 8 bytes
	function automatic logic len_ok(input logic [LEN_W-1:0] l);
		return (l >= 1) && (l <= 8);
	endfunction

	// ==============================
	// Length range
	// ==============================

	assert property (@(posedge clk) disable iff (rst_i)
		len_ok(len0_o) && len_ok(len1_o) && len_ok(len2_o) && len_ok(len3_o))
		else $error("Output length outside 1 to 8");

	// ==============================
	// Hold while disabled
	// ==============================

	// An edge with en_i low loads nothing, so every output stays put
	assert property (@(posedge clk) disable iff (rst_i)
		!en_i |=> $stable(line_o) && $stable(pc_o) && $stable(hit_o) && $stable(grp_o)
			&& $stable({len3_o, len2_o, len1_o, len0_o}))
		else $error("Outputs changed after a cycle with the enable low");

	// Reset values still visible on the first cycle out of reset
	assert property (@(posedge clk) $fell(rst_i) |-> !hit_o && (pc_o == RST_PC))
		else $error("Wrong hit or pc right after reset");

endmodule

bind ild_top ild_checker u_checker (
	.clk    (clk),
	.rst_i  (rst_i),
	.en_i   (en_i),
	.line_o (line_o),
	.pc_o   (pc_o),
	.hit_o  (hit_o),
	.grp_o  (grp_o),
	.len0_o (len0_o),
	.len1_o (len1_o),
	.len2_o (len2_o),
	.len3_o (len3_o)
);

//--- verification/ild_tb.sv
`timescale 1ns/10ps

module ild_tb;

	import ild_pkg::*;

	// Six directed tests, each budgeted at 40 clock cycles, plus one more budget for reset
	localparam int NUM_TESTS  = 6;
	localparam int TIMEOUT_NS = 4 * 40 * (NUM_TESTS + 1);

	logic              clk;
	logic              rst_i;
	logic              en_i;
	logic [LINE_W-1:0] line_i;
	logic [PC_W-1:0]   pc_i;
	logic              hit_i;
	logic [2:0]        grp_i;
	logic [LINE_W-1:0] line_o;
	logic [PC_W-1:0]   pc_o;
	logic              hit_o;
	logic [2:0]        grp_o;
	logic [LEN_W-1:0]  len0_o;
	logic [LEN_W-1:0]  len1_o;
	logic [LEN_W-1:0]  len2_o;
	logic [LEN_W-1:0]  len3_o;

	int                n_pass;
	int                n_fail;
	logic [31:0]       rng_state;

	ild_top dut_i (
		.clk    (clk),
		.rst_i  (rst_i),
		.en_i   (en_i),
		.line_i (line_i),
		.pc_i   (pc_i),
		.hit_i  (hit_i),
		.grp_i  (grp_i),
		.line_o (line_o),
		.pc_o   (pc_o),
		.hit_o  (hit_o),
		.grp_o  (grp_o),
		.len0_o (len0_o),
		.len1_o (len1_o),
		.len2_o (len2_o),
		.len3_o (len3_o)
	);

	// 4 ns clock period
	always #2 clk = ~clk;

	// ==============================
	// Helpers and reference model
	// ==============================

	// Xorshift32 generator
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [LINE_W-1:0] rand_line();
		logic [LINE_W-1:0] l;
		for (int w = 0; w < LINE_W / 32; w++) begin
			l[w*32 +: 32] = next_rand();
		end
		return l;
	endfunction

	// Instruction length for the class field in byte bits 7 to 5
	function automatic logic [LEN_W-1:0] ref_class_len(input logic [2:0] cls);
		case (cls)
			3'd0: return 4'd1;
			3'd1: return 4'd2;
			3'd2: return 4'd3;
			3'd3: return 4'd4;
			3'd4: return 4'd5;
			3'd5: return 4'd6;
			3'd6: return 4'd8;
			default: return 4'd1;
		endcase
	endfunction

	// Walks four instructions from pc bits 4 to 0, slot 0 in the low nibble
	function automatic logic [4*LEN_W-1:0] model_lengths(input logic [LINE_W-1:0] line,
			input logic [PC_W-1:0] pc);
		int                 pos;
		logic [LEN_W-1:0]   l;
		logic [4*LEN_W-1:0] res;
		pos = pc[4:0];
		res = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			l = ref_class_len(line[pos*8+5 +: 3]);
			res[k*LEN_W +: LEN_W] = l;
			pos = (pos + l) % LINE_BYTES;
		end
		return res;
	endfunction

	// Advance to just after the next rising edge
	task automatic step();
		@(posedge clk);
		#0.5;
	endtask

	task automatic check_value(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("ERROR %0t: %s got %0h expected %0h", $time, what, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic compare_outputs(input logic [LINE_W-1:0] line, input logic [PC_W-1:0] pc,
			input logic hit, input logic [2:0] grp, input string tag);
		logic [4*LEN_W-1:0] exp;
		exp = model_lengths(line, pc);
		check_value(len0_o, exp[0*LEN_W +: LEN_W], {tag, " len0"});
		check_value(len1_o, exp[1*LEN_W +: LEN_W], {tag, " len1"});
		check_value(len2_o, exp[2*LEN_W +: LEN_W], {tag, " len2"});
		check_value(len3_o, exp[3*LEN_W +: LEN_W], {tag, " len3"});
		check_value(line_o, line, {tag, " line"});
		check_value(pc_o, pc, {tag, " pc"});
		check_value(hit_o, hit, {tag, " hit"});
		check_value(grp_o, grp, {tag, " grp"});
	endtask

	// One line through the four enabled stages, then checked against the model
	task automatic run_single(input logic [LINE_W-1:0] line, input logic [PC_W-1:0] pc,
			input logic hit, input logic [2:0] grp, input string tag);
		line_i = line;
		pc_i   = pc;
		hit_i  = hit;
		grp_i  = grp;
		en_i   = 1'b1;
		repeat (4) step();
		compare_outputs(line, pc, hit, grp, tag);
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("Test %s finished with %0d errors", name, n_fail - fails_before);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_reset();
		int f0;
		f0 = n_fail;
		check_value({len3_o, len2_o, len1_o, len0_o}, 16'h1111, "reset lengths");
		check_value(hit_o, 1'b0, "reset hit");
		check_value(grp_o, 3'd0, "reset grp");
		check_value(pc_o, 32'hFFFC0000, "reset pc");
		check_value(line_o, {LINE_W{1'b1}}, "reset line");
		report_test("reset", f0);
	endtask

	task automatic test_known_sequence();
		int                f0;
		logic [LINE_W-1:0] l;
		f0 = n_fail;
		// IMM8 at 0, MEM at 2, LONG at 5, BRANCH at 13, ALU elsewhere
		l = '0;
		l[0*8 +: 8]  = 8'h20;
		l[2*8 +: 8]  = 8'h40;
		l[5*8 +: 8]  = 8'hC0;
		l[13*8 +: 8] = 8'h80;
		run_single(l, 32'h0000_1000, 1'b1, 3'd5, "known");
		check_value({len3_o, len2_o, len1_o, len0_o}, 16'h5832, "known literal lengths");
		report_test("known_sequence", f0);
	endtask

	task automatic test_all_classes();
		int                f0;
		int                s;
		logic [LINE_W-1:0] l;
		logic [31:0]       r;
		f0 = n_fail;
		for (int c = 0; c < 8; c++) begin
			// Spread the start offset over the line for each class
			s = (c * 5 + 3) % LINE_BYTES;
			l = rand_line();
			r = next_rand();
			l[s*8 +: 8] = {c[2:0], r[4:0]};
			run_single(l, {r[31:5], s[4:0]}, r[8], r[11:9], $sformatf("class %0d", c));
			check_value(len0_o, ref_class_len(c[2:0]), $sformatf("class %0d len0", c));
		end
		report_test("all_classes", f0);
	endtask

	task automatic test_wrap();
		int                f0;
		logic [LINE_W-1:0] l;
		f0 = n_fail;
		// LONG at 29 wraps to 5, IMM32 there leads to 11, IMM16 there to 15
		l = rand_line();
		l[29*8 +: 8] = 8'hC3;
		l[5*8 +: 8]  = 8'hA1;
		l[11*8 +: 8] = 8'h67;
		run_single(l, 32'h0004_005D, 1'b0, 3'd2, "wrap");
		check_value({len2_o, len1_o, len0_o}, 12'h468, "wrap literal lengths");
		report_test("wrap", f0);
	endtask

	task automatic test_pipeline();
		int                f0;
		int                edges;
		int                idx;
		logic [31:0]       r;
		logic [LINE_W-1:0] lines [8];
		logic [PC_W-1:0]   pcs [8];
		logic [3:0]        sides [8];
		logic [LINE_W-1:0] snap_line;
		logic [PC_W-1:0]   snap_pc;
		logic [3:0]        snap_side;
		logic [15:0]       snap_lens;
		f0 = n_fail;
		for (int i = 0; i < 8; i++) begin
			lines[i] = rand_line();
			pcs[i]   = next_rand();
			r        = next_rand();
			sides[i] = r[3:0];
		end
		edges = 0;
		// Enable drops for cycles 6 to 9, while three lines are still in flight
		for (int c = 0; c < 16; c++) begin
			en_i = (c < 6 || c > 9);
			if (edges < 8) begin
				line_i = lines[edges];
				pc_i   = pcs[edges];
				{hit_i, grp_i} = sides[edges];
			end else begin
				line_i = rand_line();
				pc_i   = next_rand();
			end
			snap_line = line_o;
			snap_pc   = pc_o;
			snap_side = {hit_o, grp_o};
			snap_lens = {len3_o, len2_o, len1_o, len0_o};
			step();
			if (en_i) begin
				edges++;
				idx = edges - 4;
				if (idx >= 0 && idx < 8) begin
					compare_outputs(lines[idx], pcs[idx], sides[idx][3], sides[idx][2:0],
						$sformatf("pipe line %0d", idx));
				end
			end else begin
				check_value(line_o, snap_line, "hold line");
				check_value(pc_o, snap_pc, "hold pc");
				check_value({hit_o, grp_o}, snap_side, "hold hit and grp");
				check_value({len3_o, len2_o, len1_o, len0_o}, snap_lens, "hold lengths");
			end
		end
		report_test("pipeline", f0);
	endtask

	task automatic test_random();
		int          f0;
		logic [31:0] r;
		f0 = n_fail;
		for (int i = 0; i < 20; i++) begin
			r = next_rand();
			run_single(rand_line(), next_rand(), r[0], r[3:1], $sformatf("random %0d", i));
		end
		report_test("random", f0);
	endtask

	// ==============================
	// Main sequence and watchdog
	// ==============================

	initial begin
		clk       = 1'b0;
		rst_i     = 1'b1;
		en_i      = 1'b0;
		line_i    = '0;
		pc_i      = '0;
		hit_i     = 1'b0;
		grp_i     = 3'd0;
		n_pass    = 0;
		n_fail    = 0;
		rng_state = 32'hbdc3;
		repeat (16) @(posedge clk);
		#0.5;
		rst_i = 1'b0;
		test_reset();
		test_known_sequence();
		test_all_classes();
		test_wrap();
		test_pipeline();
		test_random();
		$display("Checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Run timed out after %0d ns before all tests finished", TIMEOUT_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule
